// File: sources.f
rtl/z80_bus_pkg.sv
rtl/z80_bus_if.sv
rtl/z80_bus_sampler.sv
rtl/ram_access.sv
rtl/io_port_regs.sv
rtl/data_bus_mux.sv
rtl/z80_bus_bridge.sv
sim/bridge_checker.sv
sim/tb_z80_bus_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the Z80 bus bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module tb_z80_bus_bridge \
   -f sources.f \
   -o sim_z80_bus_bridge

./obj_dir/sim_z80_bus_bridge > sim.log
cat sim.log

if grep -q "^TEST RESULT: PASS$" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi

// File: sim/tb_z80_bus_bridge.sv
// **************************************************
// Testbench top for the Z80 bus bridge
// Clock, reset, Z80 bus cycle driver, RAM responder,
// random stimulus, timeout and final verdict
// **************************************************

`timescale 1ns/100ps

module tb_z80_bus_bridge import z80_bus_pkg::*; ();

   localparam int NUM_CYCLES = 240;                    // Random host bus cycles
   localparam int ZCLK_HALF  = 4;                      // CMD_CLK cycles per Z80 clock half
   localparam int IDLE_GAP   = 6;                      // Idle CMD_CLK cycles after a bus cycle
   localparam int MAX_CYCLES = NUM_CYCLES * 40 + 400;  // 39 CMD_CLK per bus cycle plus margin

   logic                   CMD_CLK, reset;
   logic                   z80_clk, z80_m1n, z80_mreqn, z80_iorqn, z80_rdn, z80_wrn;
   logic [ADDR_W-1:0]      z80_addr;
   logic [7:0]             z80_data_in, data_out;
   logic                   data_oe;
   logic                   cmd_valid, cmd_ready, cmd_write, cmd_read_valid;
   logic [CMD_ADDR_W-1:0]  cmd_addr;
   logic [7:0]             cmd_write_data, cmd_read_data;
   logic [31:0]            sd_sector;
   logic                   sd_op_ena, sd_busy, geo_lo_strobe, geo_hi_strobe, fifo_stat_strobe;
   logic [1:0]             sd_wr_ena;
   logic [7:0]             sd_status, geo_lo, geo_hi, fifo_stat;
   int                     test_count, error_count, fail_count;
   int                     cycle_count;
   logic [7:0]             ram [logic [CMD_ADDR_W-1:0]];  // Sparse responder memory

   z80_bus_bridge i_z80_bus_bridge (.*);
   bridge_checker i_checker (.*);

   initial begin
      CMD_CLK = 1'b0;
      forever #20 CMD_CLK = ~CMD_CLK;   // 40 ns period
   end

   // Unwritten RAM reads back a pattern of the full address
   function automatic logic [7:0] fill_byte(input logic [CMD_ADDR_W-1:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
   endfunction

   function automatic logic [7:0] pick_port(input int unsigned sel);
      case (sel)
         0: return SD_DATA_PORT;
         1: return SD_SECTOR_PORT;
         2: return SD_RDWR_PORT;
         3: return SD_ARG_PTR_PORT;
         4: return GEO_LO_PORT;
         5: return GEO_HI_PORT;
         6: return FIFO_STAT_PORT;
         7: return MMU_LO_PORT;
         8: return MMU_HI_PORT;
         default: return 8'($urandom_range(0, 239));   // Unlisted port
      endcase
   endfunction

   // One host cycle of 4 Z80 clocks followed by an idle gap
   task automatic bus_cycle(input logic mreq, input logic rd, input logic m1,
                            input logic [ADDR_W-1:0] addr, input logic [7:0] data);
      @(negedge CMD_CLK);
      z80_addr    = addr;
      z80_data_in = data;
      sd_busy     = ($urandom_range(0, 3) == 0);
      sd_status   = 8'($urandom);
      fifo_stat   = 8'($urandom);
      z80_m1n     = !m1;
      z80_mreqn   = !mreq;
      z80_iorqn   = mreq;
      z80_rdn     = !rd;
      z80_wrn     = rd;
      repeat (8) begin
         repeat (ZCLK_HALF) @(negedge CMD_CLK);
         z80_clk = ~z80_clk;
      end
      {z80_m1n, z80_mreqn, z80_iorqn, z80_rdn, z80_wrn} = '1;   // Back to idle
      repeat (IDLE_GAP) @(negedge CMD_CLK);
   endtask

   // **************************************************
   // RAM responder with random stalls and read delay
   // **************************************************
   initial begin : ready_stalls
      cmd_ready = 1'b0;
      forever begin
         @(negedge CMD_CLK);
         cmd_ready = ($urandom_range(0, 2) != 0);   // Stall about a third of cycles
      end
   end

   initial begin : ram_responder
      logic [7:0] rd_byte;
      cmd_read_valid = 1'b0;
      cmd_read_data  = '0;
      forever begin
         @(posedge CMD_CLK);
         if (cmd_valid && cmd_ready && cmd_write) begin
            ram[cmd_addr] = cmd_write_data;
         end else if (cmd_valid && cmd_ready) begin
            rd_byte = ram.exists(cmd_addr) ? ram[cmd_addr] : fill_byte(cmd_addr);
            repeat ($urandom_range(0, 3)) @(posedge CMD_CLK);
            @(negedge CMD_CLK);
            cmd_read_data  = rd_byte;
            cmd_read_valid = 1'b1;
            @(negedge CMD_CLK);
            cmd_read_valid = 1'b0;
         end
      end
   end

   always @(posedge CMD_CLK) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == MAX_CYCLES) begin
         $display("Run stopped after %0d CMD_CLK cycles, bus cycles never finished", MAX_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // **************************************************
   // Random stimulus
   // **************************************************
   initial begin : stimulus
      int unsigned        seed_ret;
      int unsigned        kind;      // 0 mem write, 1 mem read, 2 port write, 3 port read
      logic [2:0]         window;
      logic [ADDR_W-1:0]  addr;
      seed_ret    = $urandom(32'h0550b683);
      reset       = 1'b1;
      z80_clk     = 1'b0;
      {z80_m1n, z80_mreqn, z80_iorqn, z80_rdn, z80_wrn} = '1;
      z80_addr    = '0;
      z80_data_in = '0;
      sd_busy     = 1'b0;
      sd_status   = '0;
      fifo_stat   = '0;
      repeat (10) @(posedge CMD_CLK);   // Ten clock edges in reset
      @(negedge CMD_CLK);
      reset = 1'b0;
      for (int i = 0; i < NUM_CYCLES; i++) begin
         kind   = $urandom_range(0, 3);
         window = ($urandom_range(0, 3) == 0) ? 3'($urandom) : 3'b010;
         if (kind < 2) addr = {window, 19'($urandom_range(0, 31))};   // Small offsets revisit bytes
         else addr = {14'($urandom), pick_port($urandom_range(0, 9))};
         bus_cycle(kind < 2, kind[0], (kind == 1) && ($urandom_range(0, 1) == 1),
                   addr, 8'($urandom));
      end
      repeat (4) @(negedge CMD_CLK);
      $display("Done: %0d tests, %0d passed, %0d failed, %0d errors",
               test_count, test_count - fail_count, fail_count, error_count);
      if (error_count == 0 && fail_count == 0 && test_count == NUM_CYCLES + 1) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sim/bridge_checker.sv
// **************************************************
// Checker for the Z80 bus bridge testbench
// Reference model of RAM, MMU and SD sector state,
// per bus cycle comparisons and result lines
// **************************************************

`timescale 1ns/100ps

module bridge_checker import z80_bus_pkg::*; (
   input  logic                   CMD_CLK, reset,
   input  logic                   z80_mreqn, z80_iorqn, z80_rdn,
   input  logic [ADDR_W-1:0]      z80_addr,
   input  logic [7:0]             z80_data_in, data_out,
   input  logic                   data_oe, cmd_valid, cmd_ready, cmd_write,
   input  logic [CMD_ADDR_W-1:0]  cmd_addr,
   input  logic [7:0]             cmd_write_data,
   input  logic [31:0]            sd_sector,
   input  logic                   sd_op_ena, sd_busy, geo_lo_strobe, geo_hi_strobe,
   input  logic                   fifo_stat_strobe,
   input  logic [1:0]             sd_wr_ena,
   input  logic [7:0]             sd_status, geo_lo, geo_hi, fifo_stat,
   output int                     test_count, error_count, fail_count
);

   localparam logic [2:0] WINDOW = 3'b010;   // Memory window of the DUT

   logic [7:0]             mem_model [logic [CMD_ADDR_W-1:0]];
   logic [7:0]             mmu_lo, mmu_hi, wdata, port, exp_data, got_data, got_wdata, geo_val;
   logic [31:0]            sector;            // Model of sd_sector
   logic [1:0]             ptr, wr_ena_seen;  // Argument pointer model
   logic [ADDR_W-1:0]      addr;
   logic [CMD_ADDR_W-1:0]  exp_addr, got_addr;
   logic                   after_reset, active, is_mem, is_rd, in_win, busy, got_write, test_bad;
   int                     quiet, xfers, oe_cycles, oe_live;
   int                     op_pulses, lo_pulses, hi_pulses, fifo_pulses;

   // Same address pattern as the RAM responder
   function automatic logic [7:0] model_read(input logic [CMD_ADDR_W-1:0] a);
      if (mem_model.exists(a)) return mem_model[a];
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'hA5;
   endfunction

   function automatic logic [7:0] port_read_value(input logic [7:0] p);
      case (p)
         SD_SECTOR_PORT:  return sector[8*ptr +: 8];
         SD_ARG_PTR_PORT: return {6'b0, ptr};
         MMU_LO_PORT:     return mmu_lo;
         MMU_HI_PORT:     return mmu_hi;
         SD_DATA_PORT:    return sd_status;
         FIFO_STAT_PORT:  return fifo_stat;
         default:         return 8'hFF;
      endcase
   endfunction

   function automatic string cycle_name();
      if (is_mem) return is_rd ? "mem read" : "mem write";
      return is_rd ? "port read" : "port write";
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
         error_count++;
         test_bad = 1'b1;
      end
   endtask

   task automatic note_failure(input string what);
      $display("At %0t ns, test %0d: %s", $time, test_count + 1, what);
      error_count++;
      test_bad = 1'b1;
   endtask

   task automatic finish_test(input string name);
      test_count++;
      if (test_bad) fail_count++;
      $display("test %0d %s: %s", test_count, name, test_bad ? "failed" : "ok");
   endtask

   // **************************************************
   // Compare a finished host cycle against the model
   // **************************************************
   task automatic evaluate_cycle();
      logic mem_req;
      logic port_wr;
      logic oe_due;
      mem_req  = is_mem && in_win;
      port_wr  = !is_mem && !is_rd;
      oe_due   = is_rd && (mem_req || !is_mem);   // Reads outside the window drive nothing
      test_bad = 1'b0;
      check_value("RAM transfer count", xfers, mem_req ? 1 : 0);
      if (mem_req && xfers == 1) begin
         check_value("cmd_addr", got_addr, exp_addr);
         check_value("cmd_write", 32'(got_write), 32'(!is_rd));
         if (!is_rd) begin
            check_value("cmd_write_data", 32'(got_wdata), 32'(wdata));
            mem_model[exp_addr] = wdata;
         end
      end
      if (oe_due && oe_cycles == 0) note_failure("data_oe never rose during the read cycle");
      else if (!oe_due && oe_cycles != 0) note_failure("data_oe rose on a cycle with no read data");
      else if (oe_due && oe_live == 0) note_failure("data_oe only rose after the bus went idle");
      else if (oe_due) check_value("data_out", 32'(got_data), 32'(exp_data));
      check_value("sd_op_ena pulses", op_pulses,
                  (port_wr && port == SD_RDWR_PORT && !busy) ? 1 : 0);
      if (op_pulses == 1) check_value("sd_wr_ena", 32'(wr_ena_seen), 32'(wdata[1:0]));
      check_value("geo_lo_strobe pulses", lo_pulses, (port_wr && port == GEO_LO_PORT) ? 1 : 0);
      check_value("geo_hi_strobe pulses", hi_pulses, (port_wr && port == GEO_HI_PORT) ? 1 : 0);
      if (lo_pulses + hi_pulses == 1) check_value("geo byte", 32'(geo_val), 32'(wdata));
      check_value("fifo_stat_strobe pulses", fifo_pulses,
                  (is_rd && !is_mem && port == FIFO_STAT_PORT) ? 1 : 0);
      if (port_wr) begin
         case (port)
            SD_SECTOR_PORT: begin
               sector[8*ptr +: 8] = wdata;   // Lowest byte first
               ptr = ptr + 2'd1;
            end
            SD_ARG_PTR_PORT: ptr    = wdata[1:0];
            MMU_LO_PORT:     mmu_lo = wdata;
            MMU_HI_PORT:     mmu_hi = wdata;
            default: ;
         endcase
      end
      check_value("sd_sector", sd_sector, sector);
      finish_test($sformatf("%s at %06h", cycle_name(), addr));
   endtask

   always @(posedge CMD_CLK) begin
      if (reset) begin
         after_reset = 1'b1;
         active      = 1'b0;
         mmu_lo      = '0;
         mmu_hi      = '0;
         sector      = '0;
         ptr         = '0;
      end else if (after_reset) begin
         after_reset = 1'b0;
         test_bad    = 1'b0;
         check_value("cmd_valid", 32'(cmd_valid), 0);
         check_value("data_oe", 32'(data_oe), 0);
         check_value("sd_op_ena", 32'(sd_op_ena), 0);
         check_value("geo and fifo strobes",
                     32'({geo_lo_strobe, geo_hi_strobe, fifo_stat_strobe}), 0);
         check_value("sd_sector", sd_sector, 0);
         finish_test("state after reset");
      end else if (!active) begin
         if (!(z80_mreqn && z80_iorqn)) begin   // Host cycle starts here
            active      = 1'b1;
            addr        = z80_addr;
            wdata       = z80_data_in;
            port        = z80_addr[7:0];
            is_mem      = !z80_mreqn;
            is_rd       = !z80_rdn;
            busy        = sd_busy;
            in_win      = (z80_addr[21:19] == WINDOW);
            exp_addr    = {mmu_hi[4:0], mmu_lo, z80_addr[18:0]};
            exp_data    = is_mem ? model_read(exp_addr) : port_read_value(port);
            quiet       = 0;
            xfers       = 0;
            oe_cycles   = 0;
            oe_live     = 0;
            op_pulses   = 0;
            lo_pulses   = 0;
            hi_pulses   = 0;
            fifo_pulses = 0;
         end
      end else begin
         if (cmd_valid && cmd_ready) begin
            xfers++;
            got_addr  = cmd_addr;
            got_write = cmd_write;
            got_wdata = cmd_write_data;
         end
         if (data_oe) begin
            oe_cycles++;
            got_data = data_out;
            if (!(z80_mreqn && z80_iorqn)) oe_live++;   // Host still in its cycle
         end
         if (sd_op_ena) begin
            op_pulses++;
            wr_ena_seen = sd_wr_ena;
         end
         if (geo_lo_strobe) begin
            lo_pulses++;
            geo_val = geo_lo;
         end
         if (geo_hi_strobe) begin
            hi_pulses++;
            geo_val = geo_hi;
         end
         if (fifo_stat_strobe) fifo_pulses++;
         if (z80_mreqn && z80_iorqn) quiet++;   // Let the DUT drain after idle
         if (quiet == 4) begin
            evaluate_cycle();
            active = 1'b0;
         end
      end
   end

endmodule

// File: rtl/z80_bus_bridge.sv
// **************************************************
// Z80 host bus bridge, top level
// Sampler, memory path, IO port path and the
// host data output
// **************************************************

`timescale 1ns/100ps

module z80_bus_bridge import z80_bus_pkg::*; #(
   parameter logic [ADDR_W-OFFSET_W-1:0] MEMORY_RANGE     = 3'b010,
   parameter logic [PHASE_W-1:0]         WRITE_PORT_PHASE = 2,
   parameter logic [PHASE_W-1:0]         READ_PORT_PHASE  = 2
) (
   input  logic                   CMD_CLK,
   input  logic                   reset,
   // Z80 host bus
   input  logic                   z80_clk,
   input  logic                   z80_m1n,
   input  logic                   z80_mreqn,
   input  logic                   z80_iorqn,
   input  logic                   z80_rdn,
   input  logic                   z80_wrn,
   input  logic [ADDR_W-1:0]      z80_addr,
   input  logic [7:0]             z80_data_in,
   output logic [7:0]             data_out,
   output logic                   data_oe,
   // RAM requests
   output logic                   cmd_valid,
   input  logic                   cmd_ready,
   output logic [CMD_ADDR_W-1:0]  cmd_addr,
   output logic                   cmd_write,
   output logic [7:0]             cmd_write_data,
   input  logic                   cmd_read_valid,
   input  logic [7:0]             cmd_read_data,
   // Peripherals
   output logic [31:0]            sd_sector,
   output logic                   sd_op_ena,
   output logic [1:0]             sd_wr_ena,
   input  logic [7:0]             sd_status,
   input  logic                   sd_busy,
   output logic [7:0]             geo_lo,
   output logic [7:0]             geo_hi,
   output logic                   geo_lo_strobe,
   output logic                   geo_hi_strobe,
   input  logic [7:0]             fifo_stat,
   output logic                   fifo_stat_strobe
);

   logic [7:0] mmu_lo, mmu_hi;                    // MMU upper address bits
   logic       mem_resp_valid, port_resp_valid;
   logic [7:0] mem_resp_data, port_resp_data;
   logic       host_idle;

   z80_bus_if z80_bus ();

   assign host_idle = (z80_bus.op == bus_idle);

   z80_bus_sampler i_sampler (
      .CMD_CLK, .reset,
      .z80_clk, .z80_m1n, .z80_mreqn, .z80_iorqn, .z80_rdn, .z80_wrn,
      .z80_addr, .z80_data_in,
      .bus (z80_bus.sampler)
   );

   ram_access #(.MEMORY_RANGE(MEMORY_RANGE)) i_ram_access (
      .CMD_CLK, .reset,
      .bus (z80_bus.mem_side),
      .mmu_lo, .mmu_hi,
      .cmd_valid, .cmd_write, .cmd_ready, .cmd_addr, .cmd_write_data,
      .cmd_read_valid, .cmd_read_data,
      .mem_resp_valid, .mem_resp_data
   );

   io_port_regs #(
      .WRITE_PORT_PHASE (WRITE_PORT_PHASE),
      .READ_PORT_PHASE  (READ_PORT_PHASE)
   ) i_io_port_regs (
      .CMD_CLK, .reset,
      .bus (z80_bus.port_side),
      .mmu_lo, .mmu_hi,
      .sd_sector, .sd_op_ena, .sd_wr_ena, .sd_status, .sd_busy,
      .geo_lo, .geo_hi, .geo_lo_strobe, .geo_hi_strobe,
      .fifo_stat, .fifo_stat_strobe,
      .port_resp_valid, .port_resp_data
   );

   data_bus_mux i_data_bus_mux (
      .CMD_CLK, .reset,
      .bus_idle (host_idle),
      .mem_resp_valid, .mem_resp_data,
      .port_resp_valid, .port_resp_data,
      .data_out, .data_oe
   );

endmodule

// File: rtl/data_bus_mux.sv
// **************************************************
// Host data output
// Holds the last memory or port answer on the
// bus until the host cycle ends
// **************************************************

`timescale 1ns/100ps

module data_bus_mux (
   input  logic       CMD_CLK,
   input  logic       reset,
   input  logic       bus_idle,          // Host cycle over
   input  logic       mem_resp_valid,
   input  logic [7:0] mem_resp_data,
   input  logic       port_resp_valid,
   input  logic [7:0] port_resp_data,
   output logic [7:0] data_out,
   output logic       data_oe
);

   always_ff @(posedge CMD_CLK) begin
      if (reset) data_oe <= 1'b0;
      else if (bus_idle) data_oe <= 1'b0;                            // Release the bus
      else if (mem_resp_valid || port_resp_valid) data_oe <= 1'b1;
   end

   // Paths never answer in the same host cycle
   always_ff @(posedge CMD_CLK) begin
      if (mem_resp_valid) data_out <= mem_resp_data;
      else if (port_resp_valid) data_out <= port_resp_data;
   end

endmodule

// File: rtl/io_port_regs.sv
// **************************************************
// IO port path
// MMU, SD sector and command registers, geometry
// and FIFO strobes, port read answers
// **************************************************

`timescale 1ns/100ps

module io_port_regs import z80_bus_pkg::*; #(
   parameter logic [PHASE_W-1:0] WRITE_PORT_PHASE = 2,  // Phase where write data is taken
   parameter logic [PHASE_W-1:0] READ_PORT_PHASE  = 2   // Phase where read data answers
) (
   input  logic         CMD_CLK,
   input  logic         reset,
   z80_bus_if.port_side bus,
   output logic [7:0]   mmu_lo,
   output logic [7:0]   mmu_hi,
   output logic [31:0]  sd_sector,
   output logic         sd_op_ena,
   output logic [1:0]   sd_wr_ena,        // Init, read or write
   input  logic [7:0]   sd_status,
   input  logic         sd_busy,
   output logic [7:0]   geo_lo,
   output logic [7:0]   geo_hi,
   output logic         geo_lo_strobe,
   output logic         geo_hi_strobe,
   input  logic [7:0]   fifo_stat,
   output logic         fifo_stat_strobe,
   output logic         port_resp_valid,
   output logic [7:0]   port_resp_data
);

   logic [7:0] port;
   logic [1:0] arg_ptr;      // Sector byte select
   logic       wr_hit;       // Port write sampling point
   logic       rd_strobe;    // Early read notice
   logic       rd_answer;    // Read data point
   logic [7:0] rd_data;

   assign port      = bus.addr.io.port;
   assign wr_hit    = (bus.op == port_write) && bus.zclk_edge && (bus.phase == WRITE_PORT_PHASE);
   assign rd_strobe = (bus.op == port_read) && bus.zclk_edge && (bus.phase == '0);
   assign rd_answer = (bus.op == port_read) && bus.zclk_edge && (bus.phase == READ_PORT_PHASE);

   // **************************************************
   // Port write registers and strobes
   // **************************************************
   always_ff @(posedge CMD_CLK) begin
      if (reset) begin
         mmu_lo           <= '0;
         mmu_hi           <= '0;
         sd_sector        <= '0;
         arg_ptr          <= '0;
         sd_op_ena        <= 1'b0;
         geo_lo_strobe    <= 1'b0;
         geo_hi_strobe    <= 1'b0;
         fifo_stat_strobe <= 1'b0;
         port_resp_valid  <= 1'b0;
      end else begin
         sd_op_ena        <= 1'b0;                 // All strobes are single cycle
         geo_lo_strobe    <= 1'b0;
         geo_hi_strobe    <= 1'b0;
         fifo_stat_strobe <= rd_strobe && (port == FIFO_STAT_PORT);
         port_resp_valid  <= rd_answer;
         if (wr_hit) begin
            case (port)
               SD_SECTOR_PORT: begin
                  sd_sector[{arg_ptr, 3'b000} +: 8] <= bus.wdata;
                  arg_ptr <= arg_ptr + 1'b1;       // Wraps after the top byte
               end
               SD_ARG_PTR_PORT: arg_ptr       <= bus.wdata[1:0];
               SD_RDWR_PORT:    sd_op_ena     <= !sd_busy;  // Dropped while SD busy
               GEO_LO_PORT:     geo_lo_strobe <= 1'b1;
               GEO_HI_PORT:     geo_hi_strobe <= 1'b1;
               MMU_LO_PORT:     mmu_lo        <= bus.wdata;
               MMU_HI_PORT:     mmu_hi        <= bus.wdata;
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge CMD_CLK) begin
      if (wr_hit && (port == SD_RDWR_PORT) && !sd_busy) sd_wr_ena <= bus.wdata[1:0];
      if (wr_hit && (port == GEO_LO_PORT)) geo_lo <= bus.wdata;
      if (wr_hit && (port == GEO_HI_PORT)) geo_hi <= bus.wdata;
      if (rd_answer) port_resp_data <= rd_data;
   end

   // **************************************************
   // Port read data
   // **************************************************
   always_comb begin
      case (port)
         SD_SECTOR_PORT:  rd_data = sd_sector[{arg_ptr, 3'b000} +: 8];
         SD_ARG_PTR_PORT: rd_data = {6'b0, arg_ptr};
         MMU_LO_PORT:     rd_data = mmu_lo;
         MMU_HI_PORT:     rd_data = mmu_hi;
         SD_DATA_PORT:    rd_data = sd_status;
         FIFO_STAT_PORT:  rd_data = fifo_stat;
         default:         rd_data = PORT_UNUSED_DATA;
      endcase
   end

endmodule

// File: rtl/ram_access.sv
// **************************************************
// Memory window path
// One RAM request per host memory cycle, read
// data handed back as a response pulse
// **************************************************

`timescale 1ns/100ps

module ram_access import z80_bus_pkg::*; #(
   parameter logic [ADDR_W-OFFSET_W-1:0] MEMORY_RANGE = 3'b010  // Window select
) (
   input  logic                   CMD_CLK,
   input  logic                   reset,
   z80_bus_if.mem_side            bus,
   input  logic [7:0]             mmu_lo,
   input  logic [7:0]             mmu_hi,
   output logic                   cmd_valid,
   output logic                   cmd_write,
   input  logic                   cmd_ready,
   output logic [CMD_ADDR_W-1:0]  cmd_addr,
   output logic [7:0]             cmd_write_data,
   input  logic                   cmd_read_valid,
   input  logic [7:0]             cmd_read_data,
   output logic                   mem_resp_valid,
   output logic [7:0]             mem_resp_data
);

   logic in_window;   // Address falls in the memory window
   logic mem_cycle;   // In-window read or write on the bus
   logic sent;        // Request already accepted this host cycle
   logic rd_wait;     // Read accepted, data not back yet
   logic xfer;

   assign in_window = (bus.addr.mem.window == MEMORY_RANGE);
   assign mem_cycle = in_window && ((bus.op == mem_read) || (bus.op == mem_write));
   assign xfer      = cmd_valid && cmd_ready;

   // Request straight from the sampled bus, steady until accepted
   assign cmd_valid      = mem_cycle && !sent;
   assign cmd_write      = (bus.op == mem_write);
   assign cmd_write_data = bus.wdata;

   // MMU extends the 19 bit offset to the full RAM address
   assign cmd_addr = {mmu_hi[4:0], mmu_lo, bus.addr.mem.offset};

   always_ff @(posedge CMD_CLK) begin
      if (reset) begin
         sent    <= 1'b0;
         rd_wait <= 1'b0;
      end else if (bus.op == bus_idle) begin
         sent    <= 1'b0;          // Next host cycle may request again
         rd_wait <= 1'b0;
      end else begin
         if (xfer) sent <= 1'b1;
         if (xfer && !cmd_write) rd_wait <= 1'b1;
         else if (cmd_read_valid) rd_wait <= 1'b0;  // Only the first byte answers
      end
   end

   // Return data passes through in the same cycle
   assign mem_resp_valid = cmd_read_valid && rd_wait;
   assign mem_resp_data  = cmd_read_data;

endmodule

// File: rtl/z80_bus_sampler.sv
// **************************************************
// Z80 bus input sampler
// Registers the host bus, decodes the operation,
// tracks Z80 clock edges and the bus phase
// **************************************************

`timescale 1ns/100ps

module z80_bus_sampler import z80_bus_pkg::*; (
   input  logic                CMD_CLK,
   input  logic                reset,
   input  logic                z80_clk,
   input  logic                z80_m1n,      // Active low controls
   input  logic                z80_mreqn,
   input  logic                z80_iorqn,
   input  logic                z80_rdn,
   input  logic                z80_wrn,
   input  logic [ADDR_W-1:0]   z80_addr,
   input  logic [7:0]          z80_data_in,
   z80_bus_if.sampler          bus
);

   logic                zclk_r, zclk_r2;                       // Z80 clock edge detector
   logic                m1n_r, mreqn_r, iorqn_r, rdn_r, wrn_r;
   logic [ADDR_W-1:0]   addr_r;
   logic [7:0]          data_r;
   logic [PHASE_W-1:0]  phase;
   z80_op_t             op;
   logic                zclk_edge;

   assign zclk_edge = zclk_r ^ zclk_r2;  // Either transition counts

   // Control lines idle high out of reset so the bus reads as idle
   always_ff @(posedge CMD_CLK) begin
      if (reset) begin
         zclk_r  <= 1'b0;
         zclk_r2 <= 1'b0;
         m1n_r   <= 1'b1;
         mreqn_r <= 1'b1;
         iorqn_r <= 1'b1;
         rdn_r   <= 1'b1;
         wrn_r   <= 1'b1;
         phase   <= '0;
      end else begin
         zclk_r  <= z80_clk;
         zclk_r2 <= zclk_r;
         m1n_r   <= z80_m1n;
         mreqn_r <= z80_mreqn;
         iorqn_r <= z80_iorqn;
         rdn_r   <= z80_rdn;
         wrn_r   <= z80_wrn;
         if (op == bus_idle) phase <= '0;           // Restart at every idle gap
         else if (zclk_edge) phase <= phase + 1'b1;
      end
   end

   always_ff @(posedge CMD_CLK) begin
      addr_r <= z80_addr;
      data_r <= z80_data_in;
   end

   // **************************************************
   // Operation decode
   // **************************************************
   always_comb begin
      if (mreqn_r && iorqn_r)                                  op = bus_idle;
      else if (!mreqn_r && iorqn_r && !rdn_r && wrn_r)         op = mem_read;   // Fetch too
      else if (!mreqn_r && iorqn_r && rdn_r && !wrn_r)         op = mem_write;
      else if (m1n_r && !iorqn_r && mreqn_r && !rdn_r && wrn_r) op = port_read;
      else if (m1n_r && !iorqn_r && mreqn_r && rdn_r && !wrn_r) op = port_write;
      else                                                     op = bus_other;  // Int ack, T1
   end

   assign bus.op        = op;
   assign bus.addr      = addr_r;
   assign bus.wdata     = data_r;
   assign bus.zclk_edge = zclk_edge;
   assign bus.phase     = phase;

endmodule

// File: rtl/z80_bus_if.sv
// **************************************************
// Sampled and decoded Z80 bus state, shared by
// the memory path and the IO port path
// **************************************************

`timescale 1ns/100ps

interface z80_bus_if import z80_bus_pkg::*; ();

   z80_op_t              op;         // Decoded bus operation
   z80_addr_u            addr;       // Registered host address
   logic [7:0]           wdata;      // Registered host write data
   logic                 zclk_edge;  // One cycle per Z80 clock transition
   logic [PHASE_W-1:0]   phase;      // Z80 clock edges since bus left idle

   modport sampler   (output op, output addr, output wdata, output zclk_edge, output phase);
   modport mem_side  (input op, input addr, input wdata);
   modport port_side (input op, input addr, input wdata, input zclk_edge, input phase);

endinterface

// File: rtl/z80_bus_pkg.sv
// **************************************************
// Shared definitions for the Z80 bus bridge
// Bus operation type, host address views,
// widths and peripheral port numbers
// **************************************************

package z80_bus_pkg;

   // Widths
   localparam int ADDR_W     = 22;         // Host address bus
   localparam int OFFSET_W   = 19;         // Offset inside the 512KB window
   localparam int CMD_ADDR_W = 32;         // RAM address
   localparam int PHASE_W    = 4;          // Z80 clock phase counter

   // Decoded bus operation, opcode fetch folds into mem_read
   typedef enum logic [2:0] {
      bus_idle,
      mem_read,
      mem_write,
      port_read,
      port_write,
      bus_other
   } z80_op_t;

   // One host address, seen as a memory access or as a port access
   typedef union packed {
      struct packed {
         logic [ADDR_W-OFFSET_W-1:0] window;  // Selects the memory window
         logic [OFFSET_W-1:0]        offset;  // Byte inside the window
      } mem;
      struct packed {
         logic [ADDR_W-9:0] unused;           // Upper lines, ignored for IO
         logic [7:0]        port;             // IO port number
      } io;
   } z80_addr_u;

   // **************************************************
   // Peripheral port numbers
   // **************************************************
   localparam logic [7:0] SD_DATA_PORT    = 8'd240;  // Reads SD status
   localparam logic [7:0] SD_SECTOR_PORT  = 8'd241;  // 32 bit sector, byte at a time
   localparam logic [7:0] SD_RDWR_PORT    = 8'd242;  // Starts an SD operation
   localparam logic [7:0] SD_ARG_PTR_PORT = 8'd243;  // Sector byte pointer
   localparam logic [7:0] GEO_LO_PORT     = 8'd246;
   localparam logic [7:0] GEO_HI_PORT     = 8'd247;
   localparam logic [7:0] FIFO_STAT_PORT  = 8'd248;  // Geometry FIFO status
   localparam logic [7:0] MMU_LO_PORT     = 8'd250;
   localparam logic [7:0] MMU_HI_PORT     = 8'd251;

   localparam logic [7:0] PORT_UNUSED_DATA = 8'hFF;  // Unlisted ports float high

endpackage
